// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Isrc -f src.f --top-module lsq_tb
	./obj_dir/Vlsq_tb | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then \
		exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src.f ====
+incdir+src
src/lsq_pkg.sv
src/lsq_entry.sv
src/lsq_slot_manager.sv
src/lsq.sv
testbench/lsq_props.sv
testbench/lsq_tb.sv

// ==== src/lsq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsq_params.svh"

module lsq
(
    input  wire logic                 clk,
    input  wire logic                 reset,

    // Requests from the hit/miss unit.
    input  wire logic                 req_valid,
    output logic                      req_ready,
    input  wire lsq_pkg::lsq_req_t    req,
    input  wire logic                 req_inflight,

    // Line fill from the memory side.
    input  wire logic                 refill_valid,
    input  wire lsq_pkg::nline_t      refill_nline,

    // Issue to the SRAM controller.
    output logic                      issue_valid,
    input  wire logic                 issue_ready,
    output lsq_pkg::lsq_issue_t       issue,

    // Credit back to the hit/miss unit.
    output logic                      crdt_valid,
    output lsq_pkg::nline_t           crdt_nline
);

    wire  lsq_pkg::lsq_vec_t   entry_valid;
    wire  lsq_pkg::lsq_vec_t   entry_eligible;
    wire  lsq_pkg::lsq_issue_t entry_issue [`LSQ_SIZE];
    lsq_pkg::lsq_vec_t         enq_vec;
    lsq_pkg::lsq_vec_t         deq_vec;
    lsq_pkg::lsq_idx_t         issue_idx;

    // ------------------------------------------------------------------
    // Slot manager
    // ------------------------------------------------------------------
    lsq_slot_manager i_slot_manager (
        .clk            (clk),
        .reset          (reset),
        .entry_valid    (entry_valid),
        .entry_eligible (entry_eligible),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .enq_vec        (enq_vec),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .deq_vec        (deq_vec),
        .issue_idx      (issue_idx)
    );

    // ------------------------------------------------------------------
    // Queue slots
    // ------------------------------------------------------------------
    for (genvar i = 0; i < `LSQ_SIZE; i++)
    begin : g_entry
        lsq_entry i_entry (
            .clk          (clk),
            .reset        (reset),
            .enq          (enq_vec[i]),
            .req          (req),
            .req_inflight (req_inflight),
            .deq          (deq_vec[i]),
            .refill_valid (refill_valid),
            .refill_nline (refill_nline),
            .valid        (entry_valid[i]),
            .eligible     (entry_eligible[i]),
            .issue        (entry_issue[i])
        );
    end

    assign issue = entry_issue[issue_idx];

    // One credit per issue handshake, tagged with the issued line.
    assign crdt_valid = issue_valid && issue_ready;
    assign crdt_nline = {issue.way, issue.set};

endmodule

`default_nettype wire

// ==== src/lsq_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_entry
(
    input  wire logic                 clk,
    input  wire logic                 reset,

    input  wire logic                 enq,
    input  wire lsq_pkg::lsq_req_t    req,
    input  wire logic                 req_inflight,
    input  wire logic                 deq,

    input  wire logic                 refill_valid,
    input  wire lsq_pkg::nline_t      refill_nline,

    output logic                      valid,
    output logic                      eligible,
    output lsq_pkg::lsq_issue_t       issue
);

    logic              valid_q;
    logic              inflight_q;
    lsq_pkg::lsq_req_t entry_q;
    logic              evicting;
    logic              refill_hit;

    assign evicting   = (entry_q.op == lsq_pkg::RAE) || (entry_q.op == lsq_pkg::WAE);
    assign refill_hit = refill_valid && valid_q && (refill_nline == entry_q.nline);

    // ------------------------------------------------------------------
    // Slot state
    // ------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q    <= 1'b0;
            inflight_q <= 1'b0;
        end
        else if (enq)
        begin
            valid_q    <= 1'b1;
            inflight_q <= req_inflight;     // Miss still waiting on its line fill.
        end
        else
        begin
            if (deq && !evicting)
                valid_q <= 1'b0;            // An eviction stays for its refill pass.
            if (refill_hit)
                inflight_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq)
            entry_q <= req;
        else if (deq && (entry_q.op == lsq_pkg::RAE))
            entry_q.op <= lsq_pkg::LOAD_REFILL;
        else if (deq && (entry_q.op == lsq_pkg::WAE))
            entry_q.op <= lsq_pkg::STORE_REFILL;
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    assign valid    = valid_q;
    assign eligible = valid_q && !inflight_q;

    always_comb
    begin
        issue.channel          = entry_q.channel;
        issue.rob_id           = entry_q.rob_id;
        issue.op               = evicting ? lsq_pkg::WB : entry_q.op;
        {issue.way, issue.set} = entry_q.nline;
        issue.wbuf_id          = entry_q.wbuf_id;
    end

endmodule

`default_nettype wire

// ==== src/lsq_params.svh ====
`ifndef LSQ_PARAMS_SVH
`define LSQ_PARAMS_SVH

// ----------------------------------------------------------------------
// Queue geometry
// ----------------------------------------------------------------------
`define LSQ_SIZE        4

// ----------------------------------------------------------------------
// Request fields
// ----------------------------------------------------------------------
`define LSQ_SET_WIDTH   4
`define LSQ_WAY_WIDTH   2
`define LSQ_ROB_WIDTH   4
`define LSQ_WBUF_WIDTH  3
`define LSQ_CHANNEL_NUM 3

`endif

// ==== src/lsq_pkg.sv ====
`default_nettype none

`include "lsq_params.svh"

package lsq_pkg;

    // ------------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------------
    typedef logic [`LSQ_SET_WIDTH-1:0]                  set_t;
    typedef logic [`LSQ_WAY_WIDTH-1:0]                  way_t;
    typedef logic [`LSQ_WAY_WIDTH+`LSQ_SET_WIDTH-1:0]   nline_t;    // Way above set.
    typedef logic [`LSQ_ROB_WIDTH-1:0]                  rob_id_t;
    typedef logic [`LSQ_WBUF_WIDTH-1:0]                 wbuf_id_t;
    typedef logic [`LSQ_CHANNEL_NUM-1:0]                channel_1hot_t;
    typedef logic [$clog2(`LSQ_SIZE)-1:0]               lsq_idx_t;
    typedef logic [`LSQ_SIZE-1:0]                       lsq_vec_t;

    // RAE and WAE evict a dirty line before the refill is serviced.
    typedef enum logic [2:0] {
        LOAD         = 3'd0,
        STORE        = 3'd1,
        RAE          = 3'd2,
        WAE          = 3'd3,
        WB           = 3'd4,
        LOAD_REFILL  = 3'd5,
        STORE_REFILL = 3'd6
    } cache_op_t;

    // ------------------------------------------------------------------
    // Request from the hit/miss unit and issue to the SRAM controller
    // ------------------------------------------------------------------
    typedef struct packed {
        channel_1hot_t channel;
        rob_id_t       rob_id;
        cache_op_t     op;
        nline_t        nline;
        wbuf_id_t      wbuf_id;
    } lsq_req_t;

    typedef struct packed {
        channel_1hot_t channel;
        rob_id_t       rob_id;
        cache_op_t     op;
        set_t          set;
        way_t          way;
        wbuf_id_t      wbuf_id;
    } lsq_issue_t;

endpackage

`default_nettype wire

// ==== src/lsq_slot_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsq_params.svh"

module lsq_slot_manager
(
    input  wire logic                 clk,
    input  wire logic                 reset,

    input  wire lsq_pkg::lsq_vec_t    entry_valid,
    input  wire lsq_pkg::lsq_vec_t    entry_eligible,

    input  wire logic                 req_valid,
    output logic                      req_ready,
    output lsq_pkg::lsq_vec_t         enq_vec,

    output logic                      issue_valid,
    input  wire logic                 issue_ready,
    output lsq_pkg::lsq_vec_t         deq_vec,
    output lsq_pkg::lsq_idx_t         issue_idx
);

    lsq_pkg::lsq_vec_t free_vec;
    lsq_pkg::lsq_vec_t alloc_vec;
    lsq_pkg::lsq_vec_t grant_vec;
    lsq_pkg::lsq_vec_t older_q [`LSQ_SIZE];     // Row i holds the slots older than slot i.

    // ------------------------------------------------------------------
    // Allocation
    // ------------------------------------------------------------------
    assign free_vec  = ~entry_valid;
    assign alloc_vec = free_vec & (~free_vec + lsq_pkg::lsq_vec_t'(1));  // Lowest free slot.
    assign req_ready = |free_vec;
    assign enq_vec   = (req_valid && req_ready) ? alloc_vec : '0;

    // ------------------------------------------------------------------
    // Age matrix
    // ------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `LSQ_SIZE; i++)
        begin
            if (reset)
                older_q[i] <= '0;
            else if (enq_vec[i])
                older_q[i] <= entry_valid;          // All slots held now are older.
            else
                older_q[i] <= older_q[i] & ~enq_vec;    // The new slot is the youngest.
        end
    end

    // ------------------------------------------------------------------
    // Oldest eligible select
    // ------------------------------------------------------------------
    // Slots that are not eligible drop out of every row, so stale bits
    // left by freed slots never block a grant.
    always_comb
    begin
        for (int i = 0; i < `LSQ_SIZE; i++)
            grant_vec[i] = entry_eligible[i] && !(|(older_q[i] & entry_eligible));
    end

    always_comb
    begin
        issue_idx = '0;
        for (int i = 0; i < `LSQ_SIZE; i++)
        begin
            if (grant_vec[i])
                issue_idx = lsq_pkg::lsq_idx_t'(i);
        end
    end

    assign issue_valid = |entry_eligible;
    assign deq_vec     = (issue_valid && issue_ready) ? grant_vec : '0;

endmodule

`default_nettype wire

// ==== testbench/lsq_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsq_params.svh"

module lsq_props
(
    input wire logic                clk,
    input wire logic                reset,
    input wire logic                req_ready,
    input wire logic                issue_valid,
    input wire logic                crdt_valid,
    input wire lsq_pkg::nline_t     crdt_nline,
    input wire lsq_pkg::lsq_vec_t   deq_vec,
    input wire lsq_pkg::lsq_issue_t entry_issue [`LSQ_SIZE]
);

    // A reset edge leaves no slot eligible.
    assert property (@(posedge clk) reset |=> !issue_valid)
        else $error("issue_valid high after a reset edge");

    // A credit goes out exactly when one slot leaves the queue.
    assert property (@(posedge clk) disable iff (reset)
                     crdt_valid == $onehot(deq_vec))
        else $error("crdt_valid differs from the slot dequeue");

    for (genvar i = 0; i < `LSQ_SIZE; i++)
    begin : g_slot
        assert property (@(posedge clk) disable iff (reset)
                         deq_vec[i] |->
                         (crdt_nline == {entry_issue[i].way, entry_issue[i].set}))
            else $error("crdt_nline differs from the line of dequeued slot %0d", i);
    end

    assert property (@(posedge clk) $fell(reset) |-> req_ready)
        else $error("req_ready low right after reset");

endmodule

bind lsq lsq_props i_props
(
    .clk         (clk),
    .reset       (reset),
    .req_ready   (req_ready),
    .issue_valid (issue_valid),
    .crdt_valid  (crdt_valid),
    .crdt_nline  (crdt_nline),
    .deq_vec     (deq_vec),
    .entry_issue (entry_issue)
);

`default_nettype wire

// ==== testbench/lsq_stimulus.txt ====
# R op nline channel rob wbuf inflight | E op nline channel rob wbuf | D drain
# F refill_nline expected_issue_valid | B back-pressure fill (all hex)
R 0 05 1 1 2 0
R 1 13 2 2 5 0
R 0 2a 4 3 1 0
R 1 3f 1 4 7 0
R 0 07 2 5 0 0
E 0 05 1 1 2
E 1 13 2 2 5
E 0 2a 4 3 1
E 1 3f 1 4 7
E 0 07 2 5 0
D
R 2 09 1 6 3 0
R 3 1c 2 7 4 0
E 4 09 1 6 3
E 5 09 1 6 3
E 4 1c 2 7 4
E 6 1c 2 7 4
D
R 0 21 4 8 1 1
R 1 02 1 9 2 0
R 0 33 2 a 6 0
E 1 02 1 9 2
E 0 33 2 a 6
F 10 0
F 21 1
E 0 21 4 8 1
D
R 0 04 1 b 0 0
R 1 15 2 c 1 0
R 0 26 4 d 2 0
R 1 37 1 e 3 0
R 0 08 2 f 4 0
E 0 04 1 b 0
E 1 15 2 c 1
E 0 26 4 d 2
E 1 37 1 e 3
E 0 08 2 f 4
B
D

// ==== testbench/lsq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsq_params.svh"

module lsq_tb;

    typedef struct {
        byte kind;
        int  f [6];
    } rec_t;

    logic                clk;
    logic                reset;
    logic                req_valid;
    logic                req_ready;
    lsq_pkg::lsq_req_t   req;
    logic                req_inflight;
    logic                refill_valid;
    lsq_pkg::nline_t     refill_nline;
    logic                issue_valid;
    logic                issue_ready;
    lsq_pkg::lsq_issue_t issue;
    logic                crdt_valid;
    lsq_pkg::nline_t     crdt_nline;

    rec_t                recs [$];
    lsq_pkg::lsq_req_t   req_q [$];
    bit                  infl_q [$];
    lsq_pkg::lsq_issue_t exp_q [$];
    int                  errors = 0;
    int                  accepted = 0;
    int                  credits = 0;
    int                  exp_total = 0;
    bit                  load_done = 0;

    lsq i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_issue();
        lsq_pkg::lsq_issue_t e;
        if (exp_q.size() == 0)
        begin
            errors++;
            $display("Error at %0t ns: an issue happened with nothing left to expect.", $time);
            return;
        end
        e = exp_q.pop_front();
        check_value("issue.op", e.op, issue.op);
        check_value("issue.set", e.set, issue.set);
        check_value("issue.way", e.way, issue.way);
        check_value("issue.channel", e.channel, issue.channel);
        check_value("issue.rob_id", e.rob_id, issue.rob_id);
        check_value("issue.wbuf_id", e.wbuf_id, issue.wbuf_id);
        check_value("crdt_nline", {e.way, e.set}, crdt_nline);
    endtask

    // Mode 0 draws issue_ready at random, 1 holds it high, 2 holds it low.
    task automatic drive_cycle(input int ready_mode);
        @(negedge clk);
        refill_valid = 1'b0;
        req_valid    = (req_q.size() > 0);
        req          = (req_q.size() > 0) ? req_q[0] : '0;
        req_inflight = (infl_q.size() > 0) ? infl_q[0] : 1'b0;
        issue_ready  = (ready_mode == 1) || ((ready_mode == 0) && ($urandom % 2 == 1));
        #1;
        if (req_valid && req_ready)
        begin
            void'(req_q.pop_front());
            void'(infl_q.pop_front());
            accepted++;
        end
        check_value("crdt_valid", issue_valid && issue_ready, crdt_valid);
        if (crdt_valid)
            credits++;
        if (issue_valid && issue_ready)
            check_issue();
    endtask

    task automatic run_record(input rec_t r);
        lsq_pkg::lsq_req_t   q;
        lsq_pkg::lsq_issue_t e;
        case (r.kind)
            "R":
            begin
                q.op      = lsq_pkg::cache_op_t'(r.f[0]);
                q.nline   = lsq_pkg::nline_t'(r.f[1]);
                q.channel = lsq_pkg::channel_1hot_t'(r.f[2]);
                q.rob_id  = lsq_pkg::rob_id_t'(r.f[3]);
                q.wbuf_id = lsq_pkg::wbuf_id_t'(r.f[4]);
                req_q.push_back(q);
                infl_q.push_back(r.f[5] != 0);
            end
            "E":
            begin
                e.op            = lsq_pkg::cache_op_t'(r.f[0]);
                {e.way, e.set}  = lsq_pkg::nline_t'(r.f[1]);
                e.channel       = lsq_pkg::channel_1hot_t'(r.f[2]);
                e.rob_id        = lsq_pkg::rob_id_t'(r.f[3]);
                e.wbuf_id       = lsq_pkg::wbuf_id_t'(r.f[4]);
                exp_q.push_back(e);
                exp_total++;
            end
            "D":
            begin
                while (req_q.size() > 0 || exp_q.size() > 0)
                    drive_cycle(0);
            end
            "F":
            begin
                do
                    drive_cycle(0);
                while (req_q.size() > 0 || exp_q.size() > 0 || issue_valid);
                @(negedge clk);
                req_valid    = 1'b0;
                issue_ready  = 1'b0;
                refill_valid = 1'b1;
                refill_nline = lsq_pkg::nline_t'(r.f[0]);
                @(negedge clk);
                refill_valid = 1'b0;
                #1;
                check_value("issue_valid", r.f[1], issue_valid);
            end
            "B":
            begin
                accepted = 0;
                repeat (3 * `LSQ_SIZE)
                begin
                    drive_cycle(2);
                    if (req_valid && !req_ready)
                        break;
                end
                check_value("accepted", `LSQ_SIZE, accepted);
                check_value("req_ready", 0, req_ready);
                drive_cycle(1);
                drive_cycle(2);
                check_value("req_ready", 1, req_ready);     // One slot was freed.
            end
            default:
            begin
                errors++;
                $display("Error: unknown record kind '%c' in the stimulus file.", r.kind);
            end
        endcase
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial
    begin
        int    fd;
        string line;
        rec_t  r;
        void'($urandom(69030));
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        req_inflight = 1'b0;
        refill_valid = 1'b0;
        refill_nline = '0;
        issue_ready  = 1'b0;
        fd = $fopen("testbench/lsq_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file.");
            $display("SOME TESTS FAILED");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#")
                begin
                    r.f = '{default: 0};
                    void'($sscanf(line, "%c %h %h %h %h %h %h", r.kind,
                                  r.f[0], r.f[1], r.f[2], r.f[3], r.f[4], r.f[5]));
                    recs.push_back(r);
                end
            end
            $fclose(fd);
            load_done = 1'b1;
            repeat (8) @(negedge clk);
            reset = 1'b0;
            #1;
            check_value("req_ready", 1, req_ready);
            check_value("issue_valid", 0, issue_valid);
            foreach (recs[i])
                run_record(recs[i]);
            check_value("credits", exp_total, credits);
            $display("Errors: %0d, credits: %0d of %0d", errors, credits, exp_total);
            if (errors == 0)
                $display("ALL TESTS PASSED");
            else
                $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Each record gets a generous bound of 200 clock cycles.
    initial
    begin
        wait (load_done);
        #(recs.size() * 200 * 8);
        $display("Timeout: the run did not finish within the cycle bound.");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
